//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f tlk2711_top.f --top-module tb_tlk2711_top \
    -o tb_tlk2711_top > build.log 2>&1 \
    && ./obj_dir/tb_tlk2711_top > sim.log 2>&1 \
    && grep -qx "TESTBENCH PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- src/tlk2711_link_pkg.sv
/*
 * Line side definitions for the TLK2711 transmit path.
 * Control words carry a K character in the low byte only.
 */

package tlk2711_link_pkg;

    ////////////////////
    // Word and entry types
    ////////////////////

    localparam int TX_WORD_W = 16;

    typedef logic [TX_WORD_W-1:0] tx_word_t;

    // One FIFO slot, payload plus framing marks
    typedef struct packed {
        tx_word_t data;
        logic     pkt_last;
        logic     job_last;
    } tx_entry_t;

    localparam int TX_FIFO_DEPTH = 16;
    localparam int TX_FIFO_AW    = 4;

    ////////////////////
    // Line codes
    ////////////////////

    localparam tx_word_t K_IDLE = 16'hC5BC;
    localparam tx_word_t K_SOF  = 16'h50FB;
    localparam tx_word_t K_EOF  = 16'h50FD;

    // K flag pairs as {tkmsb, tklsb}
    localparam logic [1:0] TK_CTRL = 2'b01;
    localparam logic [1:0] TK_DATA = 2'b00;

    // Framer phases
    typedef enum logic [2:0] {
        FR_IDLE,
        FR_SOF,
        FR_DATA,
        FR_CSUM,
        FR_EOF
    } framer_state_t;

endpackage

//--- src/tlk2711_reg_apb.sv
/*
 * APB slave with zero wait states; unmapped offsets return PSLVERR.
 * A start written while a job is busy is dropped.
 */

`timescale 1ns/1ps

module tlk2711_reg_apb (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  tlk2711_reg_pkg::apb_addr_t  i_paddr,
    input  tlk2711_reg_pkg::apb_data_t  i_pwdata,
    output tlk2711_reg_pkg::apb_data_t  o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    output tlk2711_reg_pkg::tx_cfg_t    o_cfg,
    output logic                        o_start,
    output logic                        o_loopen,
    input  logic                        i_pkt_done,
    input  logic                        i_job_done,
    output logic                        o_tx_irq
);

    import tlk2711_link_pkg::*;
    import tlk2711_reg_pkg::*;

    logic     access;
    logic     wr_en;
    logic     mapped;
    logic     start_fire;
    logic     busy_q;
    logic     done_q;
    tx_word_t pkt_cnt_q;

    assign access = i_psel & i_penable;
    assign wr_en  = access & i_pwrite;

    assign mapped = (i_paddr == REG_CTRL)     || (i_paddr == REG_SEED) ||
                    (i_paddr == REG_BODY_LEN) || (i_paddr == REG_BODY_NUM) ||
                    (i_paddr == REG_STATUS);

    assign start_fire = wr_en && (i_paddr == REG_CTRL) &&
                        i_pwdata[CTRL_START_BIT] && !busy_q;

    assign o_pready  = 1'b1;
    assign o_pslverr = access & ~mapped;
    assign o_tx_irq  = done_q;

    ////////////////////
    // Register writes
    ////////////////////

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cfg    <= '0;
            o_loopen <= 1'b0;
        end else if (wr_en) begin
            case (i_paddr)
                REG_CTRL:     o_loopen       <= i_pwdata[CTRL_LOOP_BIT];
                REG_SEED:     o_cfg.seed     <= i_pwdata[TX_WORD_W-1:0];
                REG_BODY_LEN: o_cfg.body_len <= i_pwdata[TX_WORD_W-1:0];
                REG_BODY_NUM: o_cfg.body_num <= i_pwdata[TX_WORD_W-1:0];
                default: ;
            endcase
        end
    end

    // Job control and status
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_start   <= 1'b0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            pkt_cnt_q <= '0;
        end else begin
            o_start <= start_fire;
            if (start_fire) begin
                busy_q <= 1'b1;
            end else if (i_job_done) begin
                busy_q <= 1'b0;
            end
            // Set has priority over a clear in the same cycle
            if (i_job_done) begin
                done_q <= 1'b1;
            end else if (wr_en && (i_paddr == REG_STATUS) && i_pwdata[STAT_DONE_BIT]) begin
                done_q <= 1'b0;
            end
            if (start_fire) begin
                pkt_cnt_q <= '0;
            end else if (i_pkt_done) begin
                pkt_cnt_q <= pkt_cnt_q + 1'b1;
            end
        end
    end

    ////////////////////
    // Read mux
    ////////////////////

    always_comb begin
        o_prdata = '0;
        case (i_paddr)
            REG_CTRL:     o_prdata[CTRL_LOOP_BIT] = o_loopen;
            REG_SEED:     o_prdata[TX_WORD_W-1:0] = o_cfg.seed;
            REG_BODY_LEN: o_prdata[TX_WORD_W-1:0] = o_cfg.body_len;
            REG_BODY_NUM: o_prdata[TX_WORD_W-1:0] = o_cfg.body_num;
            REG_STATUS: begin
                o_prdata[STAT_BUSY_BIT] = busy_q;
                o_prdata[STAT_DONE_BIT] = done_q;
                o_prdata[31:16]         = pkt_cnt_q;
            end
            default: ;
        endcase
    end

endmodule

//--- src/tlk2711_reg_pkg.sv
/*
 * APB register map of the transmit controller.
 * Offsets are byte addresses within an 8-bit window.
 */

package tlk2711_reg_pkg;

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    typedef logic [APB_AW-1:0] apb_addr_t;
    typedef logic [APB_DW-1:0] apb_data_t;

    ////////////////////
    // Register offsets
    ////////////////////

    localparam apb_addr_t REG_CTRL     = 8'h00;
    localparam apb_addr_t REG_SEED     = 8'h04;
    localparam apb_addr_t REG_BODY_LEN = 8'h08;
    localparam apb_addr_t REG_BODY_NUM = 8'h0C;
    localparam apb_addr_t REG_STATUS   = 8'h10;

    // Bit positions inside CTRL and STATUS
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_LOOP_BIT  = 1;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

    // Job settings handed to the pattern producer
    typedef struct packed {
        tlk2711_link_pkg::tx_word_t seed;
        tlk2711_link_pkg::tx_word_t body_len;
        tlk2711_link_pkg::tx_word_t body_num;
    } tx_cfg_t;

endpackage

//--- src/tlk2711_top.sv
/*
 * Transmit only TLK2711 controller with an APB register port.
 * Single clock domain; PRBS, test mode and pre-emphasis stay off.
 */

`timescale 1ns/1ps

module tlk2711_top (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_psel,
    input  logic                        i_penable,
    input  logic                        i_pwrite,
    input  tlk2711_reg_pkg::apb_addr_t  i_paddr,
    input  tlk2711_reg_pkg::apb_data_t  i_pwdata,
    output tlk2711_reg_pkg::apb_data_t  o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    output logic                        o_tx_irq,
    output tlk2711_link_pkg::tx_word_t  o_2711_txd,
    output logic                        o_2711_tkmsb,
    output logic                        o_2711_tklsb,
    output logic                        o_2711_enable,
    output logic                        o_2711_loopen,
    output logic                        o_2711_lckrefn,
    output logic                        o_2711_testen,
    output logic                        o_2711_prbsen,
    output logic                        o_2711_pre
);

    import tlk2711_link_pkg::*;
    import tlk2711_reg_pkg::*;

    tx_cfg_t   cfg;
    logic      start;
    logic      pkt_done;
    logic      job_done;
    tx_entry_t pat_entry;
    logic      pat_valid;
    logic      pat_ready;
    tx_entry_t fifo_entry;
    logic      fifo_valid;
    logic      fifo_ready;

    // Fixed TLK2711 control pins
    assign o_2711_enable  = 1'b1;
    assign o_2711_lckrefn = 1'b1;
    assign o_2711_testen  = 1'b0;
    assign o_2711_prbsen  = 1'b0;
    assign o_2711_pre     = 1'b0;

    tlk2711_reg_apb reg_apb_inst (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .o_cfg      (cfg),
        .o_start    (start),
        .o_loopen   (o_2711_loopen),
        .i_pkt_done (pkt_done),
        .i_job_done (job_done),
        .o_tx_irq   (o_tx_irq)
    );

    tlk2711_tx_pattern tx_pattern_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_start (start),
        .i_cfg   (cfg),
        .o_entry (pat_entry),
        .o_valid (pat_valid),
        .i_ready (pat_ready)
    );

    tlk2711_tx_fifo tx_fifo_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_entry (pat_entry),
        .i_valid (pat_valid),
        .o_ready (pat_ready),
        .o_entry (fifo_entry),
        .o_valid (fifo_valid),
        .i_ready (fifo_ready)
    );

    tlk2711_tx_framer tx_framer_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_entry      (fifo_entry),
        .i_valid      (fifo_valid),
        .o_ready      (fifo_ready),
        .o_2711_txd   (o_2711_txd),
        .o_2711_tkmsb (o_2711_tkmsb),
        .o_2711_tklsb (o_2711_tklsb),
        .o_pkt_done   (pkt_done),
        .o_job_done   (job_done)
    );

endmodule

//--- src/tlk2711_tx_fifo.sv
/*
 * Single clock FIFO of TX_FIFO_DEPTH entries, depth a power of two.
 * Head entry is valid one cycle after its push.
 */

`timescale 1ns/1ps

module tlk2711_tx_fifo (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  tlk2711_link_pkg::tx_entry_t   i_entry,
    input  logic                          i_valid,
    output logic                          o_ready,
    output tlk2711_link_pkg::tx_entry_t   o_entry,
    output logic                          o_valid,
    input  logic                          i_ready
);

    import tlk2711_link_pkg::*;

    tx_entry_t               mem [TX_FIFO_DEPTH];
    logic [TX_FIFO_AW-1:0]   wr_ptr_q;
    logic [TX_FIFO_AW-1:0]   rd_ptr_q;
    logic [TX_FIFO_AW:0]     count_q;
    logic                    push;
    logic                    pop;

    assign o_ready = (count_q != (TX_FIFO_AW+1)'(TX_FIFO_DEPTH));
    assign o_valid = (count_q != '0);
    assign o_entry = mem[rd_ptr_q];

    assign push = i_valid & o_ready;
    assign pop  = o_valid & i_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= i_entry;
        end
    end

    // Pointers wrap on their own width
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- src/tlk2711_tx_framer.sv
/*
 * Frames FIFO entries as SOF, payload, checksum, EOF, then idle.
 * The line is never stalled; an empty FIFO mid packet fills with idles.
 */

`timescale 1ns/1ps

module tlk2711_tx_framer (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  tlk2711_link_pkg::tx_entry_t   i_entry,
    input  logic                          i_valid,
    output logic                          o_ready,
    output tlk2711_link_pkg::tx_word_t    o_2711_txd,
    output logic                          o_2711_tkmsb,
    output logic                          o_2711_tklsb,
    output logic                          o_pkt_done,
    output logic                          o_job_done
);

    import tlk2711_link_pkg::*;

    framer_state_t state_q;
    framer_state_t state_d;
    tx_word_t      txd_d;
    logic [1:0]    tk_d;
    tx_word_t      csum_q;
    logic          job_last_q;
    logic          pop;

    // Pull from the FIFO only while sending payload
    assign o_ready = (state_q == FR_DATA);
    assign pop     = o_ready & i_valid;

    ////////////////////
    // Next line word
    ////////////////////

    always_comb begin
        state_d = state_q;
        txd_d   = K_IDLE;
        tk_d    = TK_CTRL;
        case (state_q)
            FR_IDLE: begin
                if (i_valid) state_d = FR_SOF;
            end
            FR_SOF: begin
                txd_d   = K_SOF;
                state_d = FR_DATA;
            end
            FR_DATA: begin
                if (i_valid) begin
                    txd_d = i_entry.data;
                    tk_d  = TK_DATA;
                    if (i_entry.pkt_last) state_d = FR_CSUM;
                end
            end
            FR_CSUM: begin
                txd_d   = csum_q;
                tk_d    = TK_DATA;
                state_d = FR_EOF;
            end
            FR_EOF: begin
                txd_d   = K_EOF;
                state_d = FR_IDLE;
            end
            default: state_d = FR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q                      <= FR_IDLE;
            o_2711_txd                   <= K_IDLE;
            {o_2711_tkmsb, o_2711_tklsb} <= TK_CTRL;
            o_pkt_done                   <= 1'b0;
            o_job_done                   <= 1'b0;
            job_last_q                   <= 1'b0;
        end else begin
            state_q                      <= state_d;
            o_2711_txd                   <= txd_d;
            {o_2711_tkmsb, o_2711_tklsb} <= tk_d;
            // Pulses line up with the EOF word on the bus
            o_pkt_done                   <= (state_q == FR_EOF);
            o_job_done                   <= (state_q == FR_EOF) && job_last_q;
            if (pop && i_entry.pkt_last) begin
                job_last_q <= i_entry.job_last;
            end
        end
    end

    // Running sum of the packet payload, mod 2^16
    always_ff @(posedge clk) begin
        if (state_q == FR_SOF) begin
            csum_q <= '0;
        end else if (pop) begin
            csum_q <= csum_q + i_entry.data;
        end
    end

endmodule

//--- src/tlk2711_tx_pattern.sv
/*
 * Counting pattern source. Settings are latched on start, so later
 * register writes do not disturb a running job. A length of 0 acts as 1.
 */

`timescale 1ns/1ps

module tlk2711_tx_pattern (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_start,
    input  tlk2711_reg_pkg::tx_cfg_t      i_cfg,
    output tlk2711_link_pkg::tx_entry_t   o_entry,
    output logic                          o_valid,
    input  logic                          i_ready
);

    import tlk2711_link_pkg::*;

    logic     active_q;
    logic     push;
    logic     pkt_last;
    logic     job_last;
    tx_word_t data_q;
    tx_word_t len_q;
    tx_word_t num_q;
    tx_word_t word_cnt_q;
    tx_word_t pkt_cnt_q;

    assign push     = active_q & i_ready;
    assign pkt_last = (word_cnt_q == tx_word_t'(len_q - 1'b1));
    assign job_last = pkt_last && (pkt_cnt_q == tx_word_t'(num_q - 1'b1));

    assign o_valid          = active_q;
    assign o_entry.data     = data_q;
    assign o_entry.pkt_last = pkt_last;
    assign o_entry.job_last = job_last;

    // Position within the job
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active_q   <= 1'b0;
            word_cnt_q <= '0;
            pkt_cnt_q  <= '0;
        end else if (i_start) begin
            active_q   <= 1'b1;
            word_cnt_q <= '0;
            pkt_cnt_q  <= '0;
        end else if (push) begin
            if (pkt_last) begin
                word_cnt_q <= '0;
                pkt_cnt_q  <= pkt_cnt_q + 1'b1;
                if (job_last) begin
                    active_q <= 1'b0;
                end
            end else begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end
        end
    end

    // Payload value wraps mod 2^16 over the whole job
    always_ff @(posedge clk) begin
        if (i_start) begin
            data_q <= i_cfg.seed;
            len_q  <= (i_cfg.body_len == '0) ? tx_word_t'(1) : i_cfg.body_len;
            num_q  <= (i_cfg.body_num == '0) ? tx_word_t'(1) : i_cfg.body_num;
        end else if (push) begin
            data_q <= data_q + 1'b1;
        end
    end

endmodule

//--- tb/tb_tlk2711_top.sv
/*
 * Drives the APB port, runs directed and random jobs and parses the
 * TLK2711 line into frames. Packets of one job share one length.
 */

`timescale 1ns/1ps

module tb_tlk2711_top;

    import tlk2711_link_pkg::*;
    import tlk2711_reg_pkg::*;

    localparam int NUM_RAND = 6;
    localparam int NUM_JOBS = 3 + NUM_RAND;

    typedef enum logic [1:0] {MON_SOF, MON_BODY, MON_EOF, MON_GAP} mon_state_t;

    logic       clk;
    logic       rst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    logic       irq;
    tx_word_t   txd;
    logic       tkmsb;
    logic       tklsb;
    logic       enable;
    logic       loopen;
    logic       lckrefn;
    logic       testen;
    logic       prbsen;
    logic       pre;

    int         mismatch_cnt = 0;
    int         other_cnt = 0;
    int         cycle_cnt = 0;
    int         cycle_limit = 2000;
    integer     rand_seed;
    apb_data_t  rd_data;
    logic       rd_err;
    tx_word_t   seed_list [NUM_JOBS];
    tx_word_t   len_list [NUM_JOBS];
    tx_word_t   num_list [NUM_JOBS];
    tx_word_t   cur_seed = '0;
    tx_word_t   cur_len = 16'd1;
    int         job_id = 0;
    mon_state_t mon_state = MON_SOF;
    int         mon_pos = 0;
    int         mon_frames = 0;
    int         mon_job = 0;

    tlk2711_clk_gen clk_gen_inst (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    tlk2711_top tlk2711_top_inst (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_psel         (psel),
        .i_penable      (penable),
        .i_pwrite       (pwrite),
        .i_paddr        (paddr),
        .i_pwdata       (pwdata),
        .o_prdata       (prdata),
        .o_pready       (pready),
        .o_pslverr      (pslverr),
        .o_tx_irq       (irq),
        .o_2711_txd     (txd),
        .o_2711_tkmsb   (tkmsb),
        .o_2711_tklsb   (tklsb),
        .o_2711_enable  (enable),
        .o_2711_loopen  (loopen),
        .o_2711_lckrefn (lckrefn),
        .o_2711_testen  (testen),
        .o_2711_prbsen  (prbsen),
        .o_2711_pre     (pre)
    );

    ////////////////////
    // Reference and compare
    ////////////////////

    // Payload word at pos, or the packet checksum when pos equals len
    function automatic tx_word_t ref_line_word(input tx_word_t seed, input int len,
                                               input int first, input int pos);
        tx_word_t sum;
        int       i;
        sum = '0;
        if (pos < len) begin
            return tx_word_t'(seed + first + pos);
        end
        for (i = 0; i < len; i++) begin
            sum = sum + tx_word_t'(seed + first + i);
        end
        return sum;
    endfunction

    task automatic check_word(input string name, input tx_word_t got, input tx_word_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_k_flags(input logic msb_exp, input logic lsb_exp);
        check_bit("o_2711_tkmsb", tkmsb, msb_exp);
        check_bit("o_2711_tklsb", tklsb, lsb_exp);
    endtask

    ////////////////////
    // APB access
    ////////////////////

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    // Data and error sampled mid access phase
    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic run_job(input tx_word_t seed, input tx_word_t len, input tx_word_t num,
                           input logic poke_busy);
        apb_data_t data;
        logic      err;
        apb_write(REG_SEED, {16'h0, seed});
        apb_write(REG_BODY_LEN, {16'h0, len});
        apb_write(REG_BODY_NUM, {16'h0, num});
        cur_seed = seed;
        cur_len  = len;
        job_id++;
        apb_write(REG_CTRL, 32'h1);
        if (poke_busy) begin
            apb_read(REG_STATUS, data, err);
            check_reg("STATUS busy/done", data & 32'h3, 32'h1);
            // Second start must not restart the count
            apb_write(REG_CTRL, 32'h1);
        end
        @(negedge clk);
        while (!irq) @(negedge clk);
        if (mon_frames != int'(num)) begin
            other_cnt++;
            $display("Error at %0t: job %0d sent %0d frames instead of %0d",
                     $time, job_id, mon_frames, num);
        end
        apb_read(REG_STATUS, data, err);
        check_reg("STATUS", data, {num, 16'h0002});
        check_bit("o_pslverr", err, 1'b0);
        apb_write(REG_STATUS, 32'h2);
        @(negedge clk);
        check_bit("o_tx_irq", irq, 1'b0);
    endtask

    ////////////////////
    // Line monitor
    ////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            case (mon_state)
                MON_SOF: begin
                    if ({tkmsb, tklsb} == TK_DATA) begin
                        other_cnt++;
                        $display("Error at %0t: data word %h outside a packet", $time, txd);
                    end else if (txd == K_SOF) begin
                        if (mon_job != job_id) begin
                            mon_job    = job_id;
                            mon_frames = 0;
                        end
                        check_k_flags(1'b0, 1'b1);
                        mon_pos   = 0;
                        mon_state = MON_BODY;
                    end else begin
                        check_word("o_2711_txd", txd, K_IDLE);
                        check_k_flags(1'b0, 1'b1);
                    end
                end
                MON_BODY: begin
                    if ({tkmsb, tklsb} == TK_DATA) begin
                        check_word("o_2711_txd", txd,
                                   ref_line_word(cur_seed, int'(cur_len),
                                                 mon_frames * int'(cur_len), mon_pos));
                        if (mon_pos == int'(cur_len)) mon_state = MON_EOF;
                        mon_pos++;
                    end else begin
                        // Only idles may fill a gap inside a packet
                        check_word("o_2711_txd", txd, K_IDLE);
                        check_k_flags(1'b0, 1'b1);
                    end
                end
                MON_EOF: begin
                    check_word("o_2711_txd", txd, K_EOF);
                    check_k_flags(1'b0, 1'b1);
                    mon_frames++;
                    mon_state = MON_GAP;
                end
                default: begin
                    check_word("o_2711_txd", txd, K_IDLE);
                    check_k_flags(1'b0, 1'b1);
                    mon_state = MON_SOF;
                end
            endcase
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rand_seed = 32'h24f4;

        // Single packet, wrap of the count, many short packets
        seed_list[0] = 16'h1234;
        len_list[0]  = 16'd5;
        num_list[0]  = 16'd1;
        seed_list[1] = 16'hFFF8;
        len_list[1]  = 16'd12;
        num_list[1]  = 16'd2;
        seed_list[2] = 16'h0100;
        len_list[2]  = 16'd2;
        num_list[2]  = 16'd30;
        for (int j = 3; j < NUM_JOBS; j++) begin
            seed_list[j] = tx_word_t'($random(rand_seed));
            len_list[j]  = tx_word_t'(1 + ($unsigned($random(rand_seed)) % 20));
            num_list[j]  = tx_word_t'(1 + ($unsigned($random(rand_seed)) % 6));
        end
        for (int j = 0; j < NUM_JOBS; j++) begin
            cycle_limit += 4 * (int'(len_list[j]) * int'(num_list[j]) + int'(num_list[j]));
        end

        wait (rst_n === 1'b1);
        @(negedge clk);
        check_word("o_2711_txd", txd, K_IDLE);
        check_k_flags(1'b0, 1'b1);
        check_bit("o_tx_irq", irq, 1'b0);
        check_bit("o_pslverr", pslverr, 1'b0);
        check_bit("o_pready", pready, 1'b1);
        check_bit("o_2711_loopen", loopen, 1'b0);
        check_bit("o_2711_enable", enable, 1'b1);
        check_bit("o_2711_lckrefn", lckrefn, 1'b1);
        check_bit("o_2711_testen", testen, 1'b0);
        check_bit("o_2711_prbsen", prbsen, 1'b0);
        check_bit("o_2711_pre", pre, 1'b0);

        // Register read back and the unmapped offset
        apb_write(REG_SEED, 32'hDEAD_A5A5);
        apb_write(REG_BODY_LEN, 32'h0000_0007);
        apb_write(REG_BODY_NUM, 32'h0000_0003);
        apb_read(REG_SEED, rd_data, rd_err);
        check_reg("SEED", rd_data, 32'h0000_A5A5);
        check_bit("o_pslverr", rd_err, 1'b0);
        apb_read(REG_BODY_LEN, rd_data, rd_err);
        check_reg("BODY_LEN", rd_data, 32'h0000_0007);
        apb_read(REG_BODY_NUM, rd_data, rd_err);
        check_reg("BODY_NUM", rd_data, 32'h0000_0003);
        apb_read(REG_STATUS, rd_data, rd_err);
        check_reg("STATUS", rd_data, 32'h0);
        apb_read(8'h14, rd_data, rd_err);
        check_bit("o_pslverr", rd_err, 1'b1);

        // Loopback pin follows CTRL bit 1
        apb_write(REG_CTRL, 32'h2);
        @(negedge clk);
        check_bit("o_2711_loopen", loopen, 1'b1);
        apb_read(REG_CTRL, rd_data, rd_err);
        check_reg("CTRL", rd_data, 32'h2);
        apb_write(REG_CTRL, 32'h0);
        @(negedge clk);
        check_bit("o_2711_loopen", loopen, 1'b0);

        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(seed_list[j], len_list[j], num_list[j], j == 2);
        end

        repeat (20) @(posedge clk);
        @(negedge clk);
        if (mon_state != MON_SOF) begin
            other_cnt++;
            $display("Error at %0t: line did not return to idle after the last job", $time);
        end
        $display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- tb/tlk2711_clk_gen.sv
/*
 * Testbench clock of 8 ns and active low reset held for 3 cycles.
 */

`timescale 1ns/1ps

module tlk2711_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int HALF_PERIOD_NS = 4;
    localparam int RST_CYCLES     = 3;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

    // Release on a rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

//--- tlk2711_top.f
src/tlk2711_link_pkg.sv
src/tlk2711_reg_pkg.sv
src/tlk2711_reg_apb.sv
src/tlk2711_tx_pattern.sv
src/tlk2711_tx_fifo.sv
src/tlk2711_tx_framer.sv
src/tlk2711_top.sv
tb/tlk2711_clk_gen.sv
tb/tb_tlk2711_top.sv
